//--- build.f
verilog/ctr_pkg.sv
verilog/ctr_reg.sv
verilog/ctr_slice_fsm.sv
verilog/ctr_blk_out.sv
verilog/ctr_gen_top.sv
tb/ctr_gen_checker.sv
tb/tb_ctr_gen.sv

//--- Makefile
# Verilator flow for the CTR block generator
TOP := tb_ctr_gen

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -Wall -Wno-fatal --top-module $(TOP) -f build.f

sim:
	rm -f sim.log
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -Mdir obj_dir -f build.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

//--- tb/tb_ctr_gen.sv
// Testbench top for the CTR mode counter-block generator
// Drives IV loads, random back-pressure and a fatal error, the checker compares blocks

`timescale 1ns/1ns
`default_nettype none

module tb_ctr_gen;

  import ctr_pkg::*;

  localparam int unsigned Seed          = 32'h25a9;
  // Blocks over all tests: sequence, carry, back-pressure, reload, error
  localparam int unsigned NumBlocks     = 50 + 25 + 60 + 40 + 10;
  localparam int unsigned TimeoutCycles = NumBlocks * 8 + 200;

  logic        clk;
  logic        rst_n;
  logic        iv_valid;
  ctr_t        iv_data;
  logic        iv_ready;
  logic        blk_valid;
  ctr_t        blk_data;
  logic        blk_ready;
  logic        fatal_err;
  logic        alert;

  int unsigned err_cnt;
  int unsigned blk_cnt;
  int unsigned err_mark;
  int unsigned num_tests;
  int unsigned ready_pct;
  int unsigned cycle_cnt = 0;
  logic        blk_acc;
  logic        iv_acc;

  ctr_gen_top #(
    .CtrWidth   (CtrWidth),
    .SliceWidth (SliceWidth)
  ) u_dut (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .iv_valid_i  (iv_valid),
    .iv_i        (iv_data),
    .iv_ready_o  (iv_ready),
    .blk_valid_o (blk_valid),
    .blk_o       (blk_data),
    .blk_ready_i (blk_ready),
    .fatal_err_i (fatal_err),
    .alert_o     (alert)
  );

  ctr_gen_checker u_chk (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .iv_valid_i  (iv_valid),
    .iv_i        (iv_data),
    .iv_ready_i  (iv_ready),
    .blk_valid_i (blk_valid),
    .blk_i       (blk_data),
    .blk_ready_i (blk_ready),
    .fatal_err_i (fatal_err),
    .alert_i     (alert),
    .err_cnt_o   (err_cnt),
    .blk_cnt_o   (blk_cnt)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Run limit
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TimeoutCycles) begin
      $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  function automatic ctr_t rand_ctr();
    return {$urandom(), $urandom(), $urandom(), $urandom()};
  endfunction

  // Sample handshakes at the edge, then drive 2 ns later
  task automatic next_cycle();
    @(posedge clk);
    blk_acc = blk_valid & blk_ready;
    iv_acc  = iv_valid & iv_ready;
    #2;
    blk_ready = ($urandom_range(99) < ready_pct);
  endtask

  task automatic load_iv(input ctr_t iv);
    iv_valid = 1'b1;
    iv_data  = iv;
    next_cycle();
    while (!iv_acc) next_cycle();
    iv_valid = 1'b0;
  endtask

  task automatic stream_blocks(input int unsigned n);
    int unsigned cnt;
    cnt = 0;
    while (cnt < n) begin
      next_cycle();
      if (blk_acc) cnt = cnt + 1;
    end
  endtask

  task automatic finish_test(input string name);
    num_tests = num_tests + 1;
    $display("Test %0d %s finished with %0d errors", num_tests, name, err_cnt - err_mark);
    err_mark = err_cnt;
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    ctr_t iv;
    ctr_t mask;
    void'($urandom(Seed));
    rst_n     = 1'b0;
    iv_valid  = 1'b0;
    iv_data   = '0;
    blk_ready = 1'b0;
    fatal_err = 1'b0;
    ready_pct = 100;
    err_mark  = 0;
    num_tests = 0;
    repeat (8) @(posedge clk);
    #2;
    rst_n = 1'b1;
    next_cycle();
    finish_test("reset state");

    load_iv(rand_ctr());
    stream_blocks(50);
    finish_test("sequence");

    // Low slices near all-ones so carries ripple upward
    for (int k = 1; k <= 4; k++) begin
      mask = (ctr_t'(1) << (k * SliceWidth)) - 1'b1;
      iv   = (rand_ctr() | mask) - ctr_t'($urandom_range(3));
      load_iv(iv);
      stream_blocks(5);
    end
    load_iv('1);
    stream_blocks(5);
    finish_test("carry chain");

    ready_pct = 70;
    load_iv(rand_ctr());
    stream_blocks(60);
    finish_test("back-pressure");

    // New IV while the old sequence is still streaming
    repeat (5) begin
      load_iv(rand_ctr());
      stream_blocks(8);
    end
    finish_test("reload");

    load_iv(rand_ctr());
    stream_blocks(10);
    fatal_err = 1'b1;
    next_cycle();
    fatal_err = 1'b0;
    // An IV offered now must be refused
    iv_valid = 1'b1;
    iv_data  = rand_ctr();
    repeat (20) next_cycle();
    iv_valid = 1'b0;
    finish_test("fatal error");

    $display("Done: %0d tests, %0d blocks checked, %0d errors", num_tests, blk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/ctr_gen_checker.sv
// Monitor for the CTR block generator testbench
// Models the expected counter from the port activity and compares every block
// Error and block counts go back to the testbench top

`timescale 1ns/1ns
`default_nettype none

module ctr_gen_checker (
  input  wire logic          clk_i,
  input  wire logic          rst_ni,
  input  wire logic          iv_valid_i,
  input  wire ctr_pkg::ctr_t iv_i,
  input  wire logic          iv_ready_i,
  input  wire logic          blk_valid_i,
  input  wire ctr_pkg::ctr_t blk_i,
  input  wire logic          blk_ready_i,
  input  wire logic          fatal_err_i,
  input  wire logic          alert_i,
  output      int unsigned   err_cnt_o,
  output      int unsigned   blk_cnt_o
);

  import ctr_pkg::*;

  // Block valid two edges after the IV handshake
  localparam int unsigned FirstBlkLat = 2;

  // Model of the next expected block
  ctr_t        model = '0;
  logic        model_valid = 1'b0;

  // Tracking state
  logic        in_reset = 1'b1;
  logic        err_seen = 1'b0;
  logic        stall = 1'b0;
  ctr_t        stall_blk = '0;
  logic        lat_pend = 1'b0;
  int unsigned cycle = 0;
  int unsigned iv_cycle = 0;
  int unsigned err_cnt = 0;
  int unsigned blk_cnt = 0;

  assign err_cnt_o = err_cnt;
  assign blk_cnt_o = blk_cnt;

  task automatic report_mismatch(input string sig, input ctr_t exp, input ctr_t act);
    $display("Mismatch at %0t ns: %s expected %0h, got %0h", $time, sig, exp, act);
    err_cnt = err_cnt + 1;
  endtask

  task automatic log_failure(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    err_cnt = err_cnt + 1;
  endtask

  //////////////////////////////
  // Port monitor
  //////////////////////////////

  always @(posedge clk_i) begin
    cycle = cycle + 1;
    if (!rst_ni) begin
      in_reset    = 1'b1;
      model_valid = 1'b0;
      err_seen    = 1'b0;
      stall       = 1'b0;
      lat_pend    = 1'b0;
    end else begin
      // First edge out of reset
      if (in_reset) begin
        in_reset = 1'b0;
        if (blk_valid_i !== 1'b0) report_mismatch("blk_valid_o", 0, blk_valid_i);
        if (iv_ready_i !== 1'b1) report_mismatch("iv_ready_o", 1, iv_ready_i);
      end

      if (err_seen) begin
        // Locked until reset
        if (alert_i !== 1'b1) report_mismatch("alert_o", 1, alert_i);
        if (blk_valid_i !== 1'b0) report_mismatch("blk_valid_o", 0, blk_valid_i);
        if (iv_ready_i !== 1'b0) report_mismatch("iv_ready_o", 0, iv_ready_i);
      end else begin
        if (alert_i !== 1'b0) report_mismatch("alert_o", 0, alert_i);
        // Held block stays put
        if (stall) begin
          if (blk_valid_i !== 1'b1) begin
            report_mismatch("blk_valid_o", 1, blk_valid_i);
          end else if (blk_i !== stall_blk) begin
            report_mismatch("blk_o", stall_blk, blk_i);
          end
        end
        // No block yet one edge after the load
        if (lat_pend && cycle == iv_cycle + FirstBlkLat - 1) begin
          if (blk_valid_i !== 1'b0) report_mismatch("blk_valid_o", 0, blk_valid_i);
        end
        if (lat_pend && cycle == iv_cycle + FirstBlkLat) begin
          lat_pend = 1'b0;
          if (blk_valid_i !== 1'b1) report_mismatch("blk_valid_o", 1, blk_valid_i);
        end
      end

      // Accepted block against the model modulo 2^128
      if (blk_valid_i && blk_ready_i) begin
        if (!model_valid) begin
          log_failure("a block was transferred before any IV was loaded");
        end else begin
          if (blk_i !== model) report_mismatch("blk_o", model, blk_i);
          model   = model + 1'b1;
          blk_cnt = blk_cnt + 1;
        end
      end
      stall     = blk_valid_i && !blk_ready_i;
      stall_blk = blk_i;

      // IV handshake restarts the sequence
      if (iv_valid_i && iv_ready_i) begin
        model       = iv_i;
        model_valid = 1'b1;
        lat_pend    = 1'b1;
        iv_cycle    = cycle;
      end

      if (fatal_err_i) err_seen = 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- verilog/ctr_gen_top.sv
// Top level of the CTR mode counter-block generator
// Load an IV, then blocks IV, IV+1, ... stream out on the valid/ready block port
// fatal_err_i locks the generator with alert_o high until reset

`timescale 1ns/1ns
`default_nettype none

module ctr_gen_top #(
  parameter int unsigned CtrWidth   = ctr_pkg::CtrWidth,
  parameter int unsigned SliceWidth = ctr_pkg::SliceWidth
) (
  input  wire logic          clk_i,
  input  wire logic          rst_ni,

  // IV load
  input  wire logic          iv_valid_i,
  input  wire ctr_pkg::ctr_t iv_i,
  output      logic          iv_ready_o,

  // Counter blocks
  output      logic          blk_valid_o,
  output      ctr_pkg::ctr_t blk_o,
  input  wire logic          blk_ready_i,

  // Error and alert
  input  wire logic          fatal_err_i,
  output      logic          alert_o
);

  import ctr_pkg::*;

  // Counter register to output stage and FSM
  ctr_t       ctr_value;
  slice_t     slice_rd;

  // FSM write-back
  slice_idx_t slice_idx;
  slice_t     slice_wr;
  logic       slice_we;

  // Stage handshakes
  logic       incr;
  logic       incr_ready;
  logic       blk_empty;
  logic       alert;
  logic       iv_ready;
  logic       iv_load;

  // IV only while nothing is in flight
  assign iv_ready   = incr_ready & blk_empty & ~alert;
  assign iv_load    = iv_valid_i & iv_ready;
  assign iv_ready_o = iv_ready;
  assign alert_o    = alert;

  ctr_reg #(
    .CtrWidth   (CtrWidth),
    .SliceWidth (SliceWidth)
  ) u_reg (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .iv_valid_i  (iv_valid_i),
    .iv_ready_i  (iv_ready),
    .iv_i        (iv_i),
    .slice_idx_i (slice_idx),
    .slice_i     (slice_wr),
    .slice_we_i  (slice_we),
    .slice_o     (slice_rd),
    .ctr_o       (ctr_value)
  );

  ctr_slice_fsm #(
    .CtrWidth   (CtrWidth),
    .SliceWidth (SliceWidth)
  ) u_fsm (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .incr_i      (incr),
    .err_i       (fatal_err_i),
    .ready_o     (incr_ready),
    .alert_o     (alert),
    .slice_idx_o (slice_idx),
    .slice_i     (slice_rd),
    .slice_o     (slice_wr),
    .slice_we_o  (slice_we)
  );

  ctr_blk_out #(
    .CtrWidth (CtrWidth)
  ) u_out (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .ctr_i        (ctr_value),
    .incr_ready_i (incr_ready),
    .iv_load_i    (iv_load),
    .alert_i      (alert),
    .incr_o       (incr),
    .blk_valid_o  (blk_valid_o),
    .blk_o        (blk_o),
    .blk_ready_i  (blk_ready_i),
    .empty_o      (blk_empty)
  );

endmodule

`default_nettype wire

//--- verilog/ctr_blk_out.sv
// Output stage of the CTR block generator
// Snapshots the counter into a one-entry valid/ready register and asks for an increment
// Captures only after an IV load
// An alert drops the held block and disarms the stage

`timescale 1ns/1ns
`default_nettype none

module ctr_blk_out #(
  parameter int unsigned CtrWidth = ctr_pkg::CtrWidth
) (
  input  wire logic          clk_i,
  input  wire logic          rst_ni,

  // Counter value and FSM handshake
  input  wire ctr_pkg::ctr_t ctr_i,
  input  wire logic          incr_ready_i,
  input  wire logic          iv_load_i,
  input  wire logic          alert_i,
  output      logic          incr_o,

  // Block output
  output      logic          blk_valid_o,
  output      ctr_pkg::ctr_t blk_o,
  input  wire logic          blk_ready_i,
  output      logic          empty_o
);

  // Held block
  logic                blk_valid_q;
  logic [CtrWidth-1:0] blk_q;

  // Capture enable and arming
  logic armed_q;
  logic blk_accept;
  logic capture;

  assign blk_accept = blk_valid_q & blk_ready_i;

  // Capture when armed with room in the register and the FSM idle
  // An IV load in the same cycle takes precedence
  assign capture = armed_q & incr_ready_i & (~blk_valid_q | blk_accept) & ~iv_load_i;

  // Increment request goes out with the capture
  assign incr_o = capture;

  //////////////////////////////
  // Control
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      blk_valid_q <= 1'b0;
      armed_q     <= 1'b0;
    end else if (alert_i) begin
      blk_valid_q <= 1'b0;
      armed_q     <= 1'b0;
    end else begin
      if (iv_load_i) begin
        armed_q <= 1'b1;
      end
      if (capture) begin
        blk_valid_q <= 1'b1;
      end else if (blk_accept) begin
        blk_valid_q <= 1'b0;
      end
    end
  end

  // Block payload
  always_ff @(posedge clk_i) begin
    if (capture) begin
      blk_q <= ctr_i;
    end
  end

  // Held block disappears as soon as the alert is up
  assign blk_valid_o = blk_valid_q & ~alert_i;
  assign blk_o       = blk_q;
  assign empty_o     = ~blk_valid_q;

endmodule

`default_nettype wire

//--- verilog/ctr_slice_fsm.sv
// Slice-wise increment FSM of the CTR block generator
// Adds one to the counter held in ctr_reg, one slice per cycle, lowest slice first
// A fatal error moves it to a terminal state that holds the alert until reset

`timescale 1ns/1ns
`default_nettype none

module ctr_slice_fsm #(
  parameter int unsigned CtrWidth   = ctr_pkg::CtrWidth,
  parameter int unsigned SliceWidth = ctr_pkg::SliceWidth
) (
  input  wire logic                clk_i,
  input  wire logic                rst_ni,

  // Increment request and error input
  input  wire logic                incr_i,
  input  wire logic                err_i,
  output      logic                ready_o,
  output      logic                alert_o,

  // Slice access to the counter register
  output      ctr_pkg::slice_idx_t slice_idx_o,
  input  wire ctr_pkg::slice_t     slice_i,
  output      ctr_pkg::slice_t     slice_o,
  output      logic                slice_we_o
);

  import ctr_pkg::*;

  localparam int unsigned NumSlices     = CtrWidth / SliceWidth;
  localparam int unsigned SliceIdxWidth = $clog2(NumSlices);

  // State and datapath control
  ctr_e                     state_d, state_q;
  logic [SliceIdxWidth-1:0] slice_idx_d, slice_idx_q;
  logic                     carry_d, carry_q;

  // Slice sum with carry-out in the top bit
  logic [SliceWidth:0]      sum;

  //////////////////////////////
  // Slice adder
  //////////////////////////////

  assign sum     = {1'b0, slice_i} + {{SliceWidth{1'b0}}, carry_q};
  assign slice_o = sum[SliceWidth-1:0];

  //////////////////////////////
  // Next state logic
  //////////////////////////////

  always_comb begin
    // Defaults
    ready_o     = 1'b0;
    slice_we_o  = 1'b0;
    alert_o     = 1'b0;
    state_d     = state_q;
    slice_idx_d = slice_idx_q;
    carry_d     = carry_q;

    unique case (state_q)
      CTR_IDLE: begin
        ready_o = 1'b1;
        // Start from the lowest slice with a carry of one
        if (incr_i) begin
          slice_idx_d = '0;
          carry_d     = 1'b1;
          state_d     = CTR_INCR;
        end
      end

      CTR_INCR: begin
        // Write back this slice, carry-out feeds the next one
        slice_we_o  = 1'b1;
        slice_idx_d = slice_idx_q + 1'b1;
        carry_d     = sum[SliceWidth];
        if (slice_idx_q == SliceIdxWidth'(NumSlices - 1)) begin
          state_d = CTR_IDLE;
        end
      end

      // Terminal, left only by reset
      CTR_ERROR: begin
        alert_o = 1'b1;
      end

      // Unused encoding
      default: begin
        alert_o = 1'b1;
        state_d = CTR_ERROR;
      end
    endcase

    // Fatal error overrides everything
    if (err_i) begin
      state_d = CTR_ERROR;
    end
  end

  //////////////////////////////
  // Registers
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= CTR_IDLE;
      slice_idx_q <= '0;
      carry_q     <= 1'b0;
    end else begin
      state_q     <= state_d;
      slice_idx_q <= slice_idx_d;
      carry_q     <= carry_d;
    end
  end

  assign slice_idx_o = slice_idx_q;

endmodule

`default_nettype wire

//--- verilog/ctr_reg.sv
// Counter register of the CTR block generator
// Loaded with the IV on an IV handshake, updated one slice at a time by the FSM
// Provides the indexed slice to the FSM and the full value to the output stage

`timescale 1ns/1ns
`default_nettype none

module ctr_reg #(
  parameter int unsigned CtrWidth   = ctr_pkg::CtrWidth,
  parameter int unsigned SliceWidth = ctr_pkg::SliceWidth
) (
  input  wire logic                clk_i,
  input  wire logic                rst_ni,

  // IV load handshake
  input  wire logic                iv_valid_i,
  input  wire logic                iv_ready_i,
  input  wire ctr_pkg::ctr_t       iv_i,

  // Slice write-back from the FSM
  input  wire ctr_pkg::slice_idx_t slice_idx_i,
  input  wire ctr_pkg::slice_t     slice_i,
  input  wire logic                slice_we_i,

  // Read ports
  output      ctr_pkg::slice_t     slice_o,
  output      ctr_pkg::ctr_t       ctr_o
);

  // Counter storage
  logic [CtrWidth-1:0] ctr_q;

  // IV handshake
  logic iv_load;

  assign iv_load = iv_valid_i & iv_ready_i;

  //////////////////////////////
  // Counter register
  //////////////////////////////

  // IV load wins over a slice write
  // The two never overlap since IV is only accepted while the FSM is idle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ctr_q <= '0;
    end else if (iv_load) begin
      ctr_q <= iv_i;
    end else if (slice_we_i) begin
      ctr_q[slice_idx_i*SliceWidth +: SliceWidth] <= slice_i;
    end
  end

  //////////////////////////////
  // Read side
  //////////////////////////////

  // Indexed slice for the FSM adder
  assign slice_o = ctr_q[slice_idx_i*SliceWidth +: SliceWidth];

  // Full value for the output snapshot
  assign ctr_o = ctr_q;

endmodule

`default_nettype wire

//--- verilog/ctr_pkg.sv
// Shared definitions for the CTR mode counter-block generator
// Counter and slice widths, vector typedefs and the increment FSM state encoding
// Modules import this package and take their widths from the top-level parameters

`default_nettype none

package ctr_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////

  // Full counter width
  localparam int unsigned CtrWidth = 128;

  // Bits incremented per cycle, must divide CtrWidth
  localparam int unsigned SliceWidth = 32;

  // Derived slice count and slice index width
  localparam int unsigned NumSlices     = CtrWidth / SliceWidth;
  localparam int unsigned SliceIdxWidth = $clog2(NumSlices);

  //////////////////////////////
  // Vector types
  //////////////////////////////

  // Full counter value
  typedef logic [CtrWidth-1:0] ctr_t;

  // One counter slice
  typedef logic [SliceWidth-1:0] slice_t;

  // Index of a slice within the counter
  typedef logic [SliceIdxWidth-1:0] slice_idx_t;

  //////////////////////////////
  // FSM states
  //////////////////////////////

  // Slice increment FSM
  // 2'b11 is unused and treated as an error
  typedef enum logic [1:0] {
    CTR_IDLE  = 2'b00,
    CTR_INCR  = 2'b01,
    CTR_ERROR = 2'b10
  } ctr_e;

endpackage

`default_nettype wire
